// ==== hw/video_pkg.sv ====
package video_pkg;

    localparam int H_ACT      = 8;
    localparam int V_ACT      = 3;
    localparam int LINE_BYTES = 2 * H_ACT;
    localparam int ROW_W      = (V_ACT > 1) ? $clog2(V_ACT) : 1;
    localparam int BYTE_W     = $clog2(LINE_BYTES + 1); // counts 0 to LINE_BYTES.

    // one camera pixel as it arrives in its own clock domain.
    typedef struct packed {
        logic       vsync;
        logic       de;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } cam_bundle_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_colour_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } rgb565_bytes_t;

    // fifo word, filled as colour and drained as two bytes.
    typedef union packed {
        rgb565_colour_t colour;
        rgb565_bytes_t  bytes;
    } rgb565_t;

endpackage

// ==== hw/swap_pkg.sv ====
package swap_pkg;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WAIT_VSYNC = 3'd1,
        WAIT_CAM1  = 3'd2,
        READ_CAM1  = 3'd3,
        WAIT_CAM2  = 3'd4,
        READ_CAM2  = 3'd5
    } swap_state_t;

    localparam int FIFO_AW    = 4;            // word address bits.
    localparam int FIFO_DEPTH = 1 << FIFO_AW; // two lines of words.

    localparam int ERR_HOLD = 16; // cycles an error stays up.

endpackage

// ==== hw/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
    input  logic               wclk,
    input  logic               rclk,
    input  logic               rstn,
    input  logic               clr,
    input  logic               wr_en,
    input  video_pkg::rgb565_t wdata,
    input  logic               rd_en,
    output logic [7:0]         rdata,
    output logic               full,
    output logic               line_ready
);
    import video_pkg::*;
    import swap_pkg::*;

    rgb565_t            mem [FIFO_DEPTH];
    rgb565_t            rword;
    logic [1:0]         wclr_sync;
    logic [1:0]         rclr_sync;
    logic               wclr;
    logic               rclr;
    logic               push;
    logic [FIFO_AW:0]   wptr;
    logic [FIFO_AW:0]   wgray;
    logic [FIFO_AW:0]   rgray_w1;
    logic [FIFO_AW:0]   rgray_w2;
    logic [FIFO_AW+1:0] rptr;      // byte pointer, bit 0 picks hi or lo.
    logic [FIFO_AW+1:0] rptr_next;
    logic [FIFO_AW:0]   rgray;     // gray of the word part of rptr.
    logic [FIFO_AW:0]   wgray_r1;
    logic [FIFO_AW:0]   wgray_r2;
    logic [FIFO_AW:0]   wptr_r;
    logic [FIFO_AW:0]   fill;

    function automatic logic [FIFO_AW:0] bin2gray(input logic [FIFO_AW:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] g);
        logic [FIFO_AW:0] b;
        b[FIFO_AW] = g[FIFO_AW];
        for (int i = FIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    assign wclr = wclr_sync[1];
    assign push = wr_en && !full && !wclr;
    assign full = (wgray == {~rgray_w2[FIFO_AW:FIFO_AW-1], rgray_w2[FIFO_AW-2:0]});

    always_ff @(posedge wclk or negedge rstn) begin
        if (!rstn) begin
            wclr_sync <= 2'b11; // come out of reset cleared.
            rgray_w1  <= '0;
            rgray_w2  <= '0;
        end else begin
            wclr_sync <= {wclr_sync[0], clr};
            rgray_w1  <= rgray;
            rgray_w2  <= rgray_w1;
        end
    end

    always_ff @(posedge wclk or negedge rstn) begin
        if (!rstn) begin
            wptr  <= '0;
            wgray <= '0;
        end else if (wclr) begin
            wptr  <= '0;
            wgray <= '0;
        end else if (push) begin
            wptr  <= wptr + 1'b1;
            wgray <= bin2gray(wptr + 1'b1);
        end
    end

    always_ff @(posedge wclk) begin
        if (push) begin
            mem[wptr[FIFO_AW-1:0]] <= wdata;
        end
    end

    assign rclr       = rclr_sync[1];
    assign rptr_next  = rptr + 1'b1;
    assign wptr_r     = gray2bin(wgray_r2);
    assign fill       = wptr_r - rptr[FIFO_AW+1:1];
    assign line_ready = !rclr && (fill >= (FIFO_AW + 1)'(H_ACT));
    assign rword      = mem[rptr[FIFO_AW:1]];

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            rclr_sync <= 2'b11;
            wgray_r1  <= '0;
            wgray_r2  <= '0;
        end else begin
            rclr_sync <= {rclr_sync[0], clr};
            wgray_r1  <= wgray;
            wgray_r2  <= wgray_r1;
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            rptr  <= '0;
            rgray <= '0;
        end else if (rclr) begin
            rptr  <= '0;
            rgray <= '0;
        end else if (rd_en) begin
            rptr  <= rptr_next;
            rgray <= bin2gray(rptr_next[FIFO_AW+1:1]); // moves once the lo byte is out.
        end
    end

    always_ff @(posedge rclk) begin
        if (rd_en) begin
            rdata <= rptr[0] ? rword.bytes.lo : rword.bytes.hi;
        end
    end

endmodule

// ==== hw/error_stretch.sv ====
`timescale 1ns/1ps

module error_stretch #(
    parameter int HOLD = 16
) (
    input  logic clk,
    input  logic rstn,
    input  logic fault,
    output logic err
);

    logic [$clog2(HOLD + 1)-1:0] cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (fault) begin
            cnt <= $bits(cnt)'(HOLD); // every fault restarts the hold.
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign err = (cnt != '0);

endmodule

// ==== hw/cam_ingress.sv ====
`timescale 1ns/1ps

module cam_ingress (
    input  logic                   cam_clk,
    input  logic                   rclk,
    input  logic                   rstn,
    input  video_pkg::cam_bundle_t pack,
    input  logic                   clr,
    input  logic                   rd_en,
    output logic [7:0]             rdata,
    output logic                   line_ready,
    output logic                   err
);
    import video_pkg::*;
    import swap_pkg::*;

    rgb565_t wdata;
    logic    full;
    logic    overflow;

    // keep the top bits of each channel.
    always_comb begin
        wdata.colour.red   = pack.r[7:3];
        wdata.colour.green = pack.g[7:2];
        wdata.colour.blue  = pack.b[7:3];
    end

    assign overflow = pack.de && full; // this word is dropped.

    async_fifo fifo_inst (
        .wclk      (cam_clk),
        .rclk      (rclk),
        .rstn      (rstn),
        .clr       (clr),
        .wr_en     (pack.de),
        .wdata     (wdata),
        .rd_en     (rd_en),
        .rdata     (rdata),
        .full      (full),
        .line_ready(line_ready)
    );

    error_stretch #(
        .HOLD(ERR_HOLD)
    ) overflow_err_inst (
        .clk  (cam_clk),
        .rstn (rstn),
        .fault(overflow),
        .err  (err)
    );

endmodule

// ==== hw/line_swap_ctrl.sv ====
`timescale 1ns/1ps

module line_swap_ctrl (
    input  logic                        rclk,
    input  logic                        rstn,
    input  logic                        trig,
    input  logic                        read_en,
    input  logic                        vsync1,
    input  logic                        vsync2,
    input  logic                        line_ready1,
    input  logic                        line_ready2,
    input  logic [7:0]                  rdata1,
    input  logic [7:0]                  rdata2,
    output logic                        rd_en1,
    output logic                        rd_en2,
    output logic                        fifo_clr,
    output logic                        acquire,
    output logic                        cam_id,
    output logic                        valid,
    output logic [7:0]                  cam_data,
    output logic [video_pkg::ROW_W-1:0] cam_row,
    output logic                        vs_fault
);
    import video_pkg::*;
    import swap_pkg::*;

    swap_state_t       state;
    logic [1:0]        vs1_sync;
    logic [1:0]        vs2_sync;
    logic              vs1_q;
    logic              vs2_q;
    logic              vs1_fall;
    logic              vs2_fall;
    logic              reading;
    logic              rd_go;
    logic              last_byte;
    logic [BYTE_W-1:0] rd_cnt;   // reads issued on this line.
    logic [BYTE_W-1:0] byte_cnt; // bytes delivered on this line.
    logic [ROW_W-1:0]  row;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            vs1_sync <= '0;
            vs2_sync <= '0;
            vs1_q    <= 1'b0;
            vs2_q    <= 1'b0;
        end else begin
            vs1_sync <= {vs1_sync[0], vsync1};
            vs2_sync <= {vs2_sync[0], vsync2};
            vs1_q    <= vs1_sync[1];
            vs2_q    <= vs2_sync[1];
        end
    end

    assign vs1_fall = vs1_q && !vs1_sync[1];
    assign vs2_fall = vs2_q && !vs2_sync[1];

    assign reading   = (state == READ_CAM1) || (state == READ_CAM2);
    assign rd_go     = reading && read_en && (rd_cnt != BYTE_W'(LINE_BYTES));
    assign last_byte = valid && (byte_cnt == BYTE_W'(LINE_BYTES - 1));

    assign fifo_clr = (state == IDLE) || (state == WAIT_VSYNC);
    assign cam_id   = (state == WAIT_CAM2) || (state == READ_CAM2);
    assign cam_data = cam_id ? rdata2 : rdata1; // fifo byte is already registered.
    assign cam_row  = row;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            rd_en1   <= 1'b0;
            rd_en2   <= 1'b0;
            valid    <= 1'b0;
            rd_cnt   <= '0;
            byte_cnt <= '0;
        end else begin
            rd_en1 <= rd_go && (state == READ_CAM1);
            rd_en2 <= rd_go && (state == READ_CAM2);
            valid  <= rd_en1 || rd_en2;
            if (!reading) begin
                rd_cnt   <= '0;
                byte_cnt <= '0;
            end else begin
                if (rd_go) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (valid) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            acquire  <= 1'b0;
            vs_fault <= 1'b0;
            row      <= '0;
        end else begin
            acquire  <= 1'b0;
            vs_fault <= 1'b0;
            case (state)
                IDLE: begin
                    if (trig) begin
                        state <= WAIT_VSYNC;
                    end
                end
                WAIT_VSYNC: begin
                    if (vs1_fall != vs2_fall) begin
                        vs_fault <= 1'b1; // one camera closed its frame alone.
                        state    <= IDLE;
                    end else if (vs1_sync[1] && vs2_sync[1]) begin
                        row   <= '0;
                        state <= WAIT_CAM1;
                    end
                end
                WAIT_CAM1: begin
                    if (line_ready1) begin
                        acquire <= 1'b1;
                        state   <= READ_CAM1;
                    end
                end
                READ_CAM1: begin
                    if (last_byte) begin
                        state <= WAIT_CAM2;
                    end
                end
                WAIT_CAM2: begin
                    if (line_ready2) begin
                        acquire <= 1'b1;
                        state   <= READ_CAM2;
                    end
                end
                READ_CAM2: begin
                    if (last_byte) begin
                        if (row == ROW_W'(V_ACT - 1)) begin
                            state <= IDLE; // frame done.
                        end else begin
                            row   <= row + 1'b1;
                            state <= WAIT_CAM1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/line_swap_buffer.sv ====
`timescale 1ns/1ps

module line_swap_buffer (
    input  logic                        rclk,
    input  logic                        rstn,
    input  logic                        cam1_clk,
    input  logic                        cam2_clk,
    input  video_pkg::cam_bundle_t      cam1_pack,
    input  video_pkg::cam_bundle_t      cam2_pack,
    input  logic                        trig,
    input  logic                        read_en,
    output logic                        acquire,
    output logic                        cam_id,
    output logic                        valid,
    output logic [7:0]                  cam_data,
    output logic [video_pkg::ROW_W-1:0] cam_row,
    output logic                        error
);
    import swap_pkg::*;

    logic       fifo_clr;
    logic       rd_en1;
    logic       rd_en2;
    logic       line_ready1;
    logic       line_ready2;
    logic [7:0] rdata1;
    logic [7:0] rdata2;
    logic       err1;
    logic       err2;
    logic       vs_fault;
    logic       vs_err;

    cam_ingress cam1_ingress_inst (
        .cam_clk   (cam1_clk),
        .rclk      (rclk),
        .rstn      (rstn),
        .pack      (cam1_pack),
        .clr       (fifo_clr),
        .rd_en     (rd_en1),
        .rdata     (rdata1),
        .line_ready(line_ready1),
        .err       (err1)
    );

    cam_ingress cam2_ingress_inst (
        .cam_clk   (cam2_clk),
        .rclk      (rclk),
        .rstn      (rstn),
        .pack      (cam2_pack),
        .clr       (fifo_clr),
        .rd_en     (rd_en2),
        .rdata     (rdata2),
        .line_ready(line_ready2),
        .err       (err2)
    );

    line_swap_ctrl ctrl_inst (
        .rclk       (rclk),
        .rstn       (rstn),
        .trig       (trig),
        .read_en    (read_en),
        .vsync1     (cam1_pack.vsync), // resynchronized inside the controller.
        .vsync2     (cam2_pack.vsync),
        .line_ready1(line_ready1),
        .line_ready2(line_ready2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .rd_en1     (rd_en1),
        .rd_en2     (rd_en2),
        .fifo_clr   (fifo_clr),
        .acquire    (acquire),
        .cam_id     (cam_id),
        .valid      (valid),
        .cam_data   (cam_data),
        .cam_row    (cam_row),
        .vs_fault   (vs_fault)
    );

    error_stretch #(
        .HOLD(ERR_HOLD)
    ) vsync_err_inst (
        .clk  (rclk),
        .rstn (rstn),
        .fault(vs_fault),
        .err  (vs_err)
    );

    assign error = err1 || err2 || vs_err; // each term held in its own clock.

endmodule

// ==== testbench/line_swap_buffer_props.sv ====
`timescale 1ns/1ps

module line_swap_buffer_props (
    input logic                        rclk,
    input logic                        rstn,
    input logic                        read_en,
    input logic                        acquire,
    input logic                        valid,
    input logic [video_pkg::ROW_W-1:0] cam_row
);
    import video_pkg::*;

    // one line start is a single-cycle pulse.
    acquire_single: assert property (@(posedge rclk) disable iff (!rstn)
        acquire |=> !acquire)
        else $error("acquire stayed high for two cycles");

    // read_en to rd_en to valid is two cycles.
    valid_after_read: assert property (@(posedge rclk) disable iff (!rstn)
        valid |-> $past(read_en, 2))
        else $error("valid without read_en two cycles earlier");

    row_in_range: assert property (@(posedge rclk) disable iff (!rstn)
        cam_row < V_ACT)
        else $error("cam_row beyond the last row");

endmodule

// ==== testbench/line_swap_buffer_tb.sv ====
`timescale 1ns/1ps

module line_swap_buffer_tb;
    import video_pkg::*;

    localparam int TIMEOUT = 2000; // rclk cycles allowed per wait.

    logic             rclk;
    logic             rstn;
    logic             cam1_clk;
    logic             cam2_clk;
    cam_bundle_t      cam1_pack;
    cam_bundle_t      cam2_pack;
    logic             trig;
    logic             read_en;
    logic             acquire;
    logic             cam_id;
    logic             valid;
    logic [7:0]       cam_data;
    logic [ROW_W-1:0] cam_row;
    logic             error;
    logic [7:0]       exp1[$];
    logic [7:0]       exp2[$];
    integer           seed;

    line_swap_buffer line_swap_buffer_inst (.*);

    bind line_swap_buffer line_swap_buffer_props props_inst (
        .rclk(rclk), .rstn(rstn), .read_en(read_en),
        .acquire(acquire), .valid(valid), .cam_row(cam_row)
    );

    initial begin
        rclk = 1'b0;
        forever #2 rclk = ~rclk;
    end

    // camera clocks are offset so no edge meets an rclk edge.
    initial begin
        cam1_clk = 1'b0;
        #0.5;
        forever #3 cam1_clk = ~cam1_clk;
    end

    initial begin
        cam2_clk = 1'b0;
        #0.7;
        forever #3.5 cam2_clk = ~cam2_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    task automatic cam_tick(input int id);
        if (id == 1) begin
            @(negedge cam1_clk);
        end else begin
            @(negedge cam2_clk);
        end
    endtask

    task automatic cam_drive(input int id, input cam_bundle_t b);
        if (id == 1) begin
            cam1_pack = b;
        end else begin
            cam2_pack = b;
        end
    endtask

    // vsync, front porch, then lines of words with long blanking.
    task automatic camera_frame(input int id, input int lines, input int words, input bit record);
        cam_bundle_t b;
        logic [31:0] pix;
        b = '0;
        cam_tick(id);
        b.vsync = 1'b1;
        cam_drive(id, b);
        repeat (12) cam_tick(id);
        for (int l = 0; l < lines; l++) begin
            for (int w = 0; w < words; w++) begin
                cam_tick(id);
                pix  = $random(seed);
                b.de = 1'b1;
                b.r  = pix[23:16];
                b.g  = pix[15:8];
                b.b  = pix[7:0];
                cam_drive(id, b);
                if (record && id == 1) begin
                    exp1.push_back({pix[23:19], pix[15:13]}); // red and top of green.
                    exp1.push_back({pix[12:10], pix[7:3]});
                end else if (record) begin
                    exp2.push_back({pix[23:19], pix[15:13]});
                    exp2.push_back({pix[12:10], pix[7:3]});
                end
            end
            cam_tick(id);
            b.de = 1'b0;
            cam_drive(id, b);
            repeat (60) cam_tick(id);
        end
        b.vsync = 1'b0;
        cam_drive(id, b);
    endtask

    // vsync edges of the last frame leave the synchronizers first.
    task automatic pulse_trig();
        repeat (4) @(negedge rclk);
        trig = 1'b1;
        @(negedge rclk);
        trig = 1'b0;
    endtask

    task automatic wait_acquire();
        int n;
        n = 0;
        while (!acquire) begin
            @(negedge rclk);
            check(32'(valid), 32'd0, "valid outside a line");
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout: no acquire pulse for the next line");
            end
        end
    endtask

    task automatic read_line(input int id, input int row, input bit gaps);
        int n;
        int got;
        int r;
        logic [7:0] want;
        n   = 0;
        got = 0;
        while (got < LINE_BYTES) begin
            r       = $random(seed);
            read_en = gaps ? r[0] : 1'b1;
            @(negedge rclk);
            check(32'(acquire), 32'd0, "acquire inside a line");
            if (valid) begin
                if ((id == 0 && exp1.size() == 0) || (id == 1 && exp2.size() == 0)) begin
                    abort_run("a byte arrived that no camera wrote");
                end
                want = (id == 0) ? exp1.pop_front() : exp2.pop_front();
                check(32'(cam_id), 32'(id), "cam_id during line");
                check(32'(cam_row), 32'(row), "cam_row during line");
                check(32'(cam_data), 32'(want), "cam_data");
                got++;
            end
            n++;
            if (n > TIMEOUT) begin
                abort_run("timeout: line ended before all its bytes arrived");
            end
        end
    endtask

    task automatic read_frame(input bit gaps);
        for (int row = 0; row < V_ACT; row++) begin
            for (int id = 0; id < 2; id++) begin
                wait_acquire();
                check(32'(cam_id), 32'(id), "cam_id at acquire");
                check(32'(cam_row), 32'(row), "cam_row at acquire");
                read_line(id, row, gaps);
            end
        end
        read_en = 1'b0;
    endtask

    // waits for error at a level and checks that no line starts meanwhile.
    task automatic wait_error_level(input logic level);
        int n;
        n = 0;
        while (error !== level) begin
            @(negedge rclk);
            check(32'(acquire), 32'd0, "acquire while waiting on error");
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("timeout: error never went to %0b", level));
            end
        end
    endtask

    task automatic test_idle();
        check(32'(acquire), 32'd0, "acquire after reset");
        check(32'(cam_id), 32'd0, "cam_id after reset");
        repeat (20) begin
            @(negedge rclk);
            check(32'(acquire), 32'd0, "acquire without trig");
            check(32'(valid), 32'd0, "valid without trig");
            check(32'(error), 32'd0, "error without trig");
        end
    endtask

    task automatic test_frame(input bit gaps);
        pulse_trig();
        fork
            camera_frame(1, V_ACT, H_ACT, 1'b1);
            camera_frame(2, V_ACT, H_ACT, 1'b1);
            read_frame(gaps);
        join
        check(32'(exp1.size()), 32'd0, "camera 1 bytes left unread");
        check(32'(exp2.size()), 32'd0, "camera 2 bytes left unread");
        check(32'(error), 32'd0, "error after a clean frame");
    endtask

    // camera 1 closes a frame that camera 2 never opened.
    task automatic test_vsync_mismatch();
        cam_bundle_t b;
        b = '0;
        pulse_trig();
        cam_tick(1);
        b.vsync = 1'b1;
        cam_drive(1, b);
        repeat (10) cam_tick(1);
        b.vsync = 1'b0;
        cam_drive(1, b);
        wait_error_level(1'b1);
        wait_error_level(1'b0);
        test_frame(1'b0);
    endtask

    task automatic test_overflow();
        cam_bundle_t b;
        b = '0;
        read_en = 1'b0;
        pulse_trig();
        cam_tick(1);
        b.vsync = 1'b1;
        cam_drive(1, b); // held so the FIFOs are released.
        fork
            camera_frame(2, 1, 20, 1'b0);
            wait_error_level(1'b1);
        join
        wait_error_level(1'b0);
    endtask

    initial begin
        seed      = 99226;
        rstn      = 1'b0;
        trig      = 1'b0;
        read_en   = 1'b0;
        cam1_pack = '0;
        cam2_pack = '0;
        repeat (2) @(negedge rclk);
        rstn = 1'b1;
        test_idle();
        test_frame(1'b0);
        test_frame(1'b1);
        test_vsync_mismatch();
        test_overflow();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== line_swap_buffer.f ====
hw/video_pkg.sv
hw/swap_pkg.sv
hw/async_fifo.sv
hw/error_stretch.sv
hw/cam_ingress.sv
hw/line_swap_ctrl.sv
hw/line_swap_buffer.sv
testbench/line_swap_buffer_props.sv
testbench/line_swap_buffer_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module line_swap_buffer_tb -f line_swap_buffer.f -o line_swap_buffer_sim
	./obj_dir/line_swap_buffer_sim

clean:
	rm -rf obj_dir
